//--- files.f
design/fft_types_pkg.sv
design/fft_ctrl_pkg.sv
design/fft_delay_line.sv
design/fft_butterfly.sv
design/fft_twiddle_rom.sv
design/fft_wm.sv
design/fft_sdf_stage.sv
sim/fft_sdf_stage_sva.sv
sim/fft_sdf_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SDF stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module fft_sdf_stage_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vfft_sdf_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
   echo "failure reported in $LOG"
   exit 1
fi

exit 0

//--- sim/fft_sdf_stage_tb.sv
`timescale 1ns/1ns

module fft_sdf_stage_tb;

   localparam int  N               = 16;
   localparam int  IW              = $clog2(N);
   localparam int  HALF            = N / 2;
   localparam int  FRAMES          = 5;  // four random frames, then zeros.
   localparam int  RANDOM_FRAMES   = 4;
   localparam int  GAP_FRAME       = 2;
   localparam int  TOTAL_OUTS      = RANDOM_FRAMES * N + HALF;
   localparam int  RESET_CYCLES    = 16;
   localparam int  LAT             = fft_ctrl_pkg::STAGE_LATENCY;
   localparam int  WATCHDOG_CYCLES = 2 * (6 * N + RESET_CYCLES + LAT);
   localparam real PI              = 3.14159265358979323846;
   localparam real ONE             = 2.0 ** (fft_types_pkg::TWIDDLE_WIDTH - 1);
   localparam real W_MAX           = ONE - 1.0;

   logic                   clk;
   logic                   srst_n;
   logic                   carry_i;
   fft_types_pkg::sample_t x_re_i;
   fft_types_pkg::sample_t x_im_i;
   logic                   carry_o;
   logic [IW-1:0]          ctr_o;
   fft_types_pkg::sample_t z_re_o;
   fft_types_pkg::sample_t z_im_o;

   logic [15:0] lfsr_state = 16'd12469;
   int          stim_re [FRAMES][N];
   int          stim_im [FRAMES][N];
   int          frame_outs [FRAMES];
   int          errors      = 0;
   int          sva_fails   = 0;   // concurrent assertion failures.
   int          carry_count = 0;   // carry_o pulses.
   int          checked     = 0;   // outputs compared with the model.
   int          out_frame   = 0;
   int          prev_ctr    = -1;

   fft_sdf_stage #(
      .N (N)
   ) i_fft_sdf_stage (
      .clk     (clk),
      .srst_n  (srst_n),
      .carry_i (carry_i),
      .x_re_i  (x_re_i),
      .x_im_i  (x_im_i),
      .carry_o (carry_o),
      .ctr_o   (ctr_o),
      .z_re_o  (z_re_o),
      .z_im_o  (z_im_o)
   );

   // galois form of x^16 + x^14 + x^13 + x^11 + 1.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i]       = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   function automatic int round_near(input real v);
      return int'($floor(v + 0.5));
   endfunction

   function automatic int abs_int(input int v);
      return (v < 0) ? -v : v;
   endfunction

   // sums see the unit twiddle and halved differences see exp(-j*2*pi*k/N).
   task automatic check_output(input int f, input int m, input int act_re, input int act_im);
      int    k;
      int    h_re;
      int    h_im;
      int    tol;
      int    e_re;
      int    e_im;
      real   w_re;
      real   w_im;
      string name;
      k = m % HALF;
      if (m < HALF) begin
         h_re = (stim_re[f][k] + stim_re[f][k+HALF]) >>> 1;
         h_im = (stim_im[f][k] + stim_im[f][k+HALF]) >>> 1;
         w_re = W_MAX;
         w_im = 0.0;
         tol  = 1;
         name = "sum";
      end else begin
         h_re = (stim_re[f][k] - stim_re[f][k+HALF]) >>> 1;
         h_im = (stim_im[f][k] - stim_im[f][k+HALF]) >>> 1;
         w_re = $floor($cos(2.0 * PI * k / N) * W_MAX + 0.5);
         w_im = $floor(-$sin(2.0 * PI * k / N) * W_MAX + 0.5);
         tol  = 2;
         name = "diff";
      end
      e_re = round_near((h_re * w_re - h_im * w_im) / ONE);
      e_im = round_near((h_re * w_im + h_im * w_re) / ONE);
      assert (abs_int(act_re - e_re) <= tol) else begin
         $display("FAILED %s_re frame %0d index %0d: expected %0d, actual %0d",
                  name, f, m, e_re, act_re);
         errors++;
      end
      assert (abs_int(act_im - e_im) <= tol) else begin
         $display("FAILED %s_im frame %0d index %0d: expected %0d, actual %0d",
                  name, f, m, e_im, act_im);
         errors++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired before all frames were checked");
      $display("Simulation failed");
      $finish;
   end

   // outputs change on the rising edge.
   always @(negedge clk) begin
      if (srst_n && carry_o) begin
         if (int'(ctr_o) <= prev_ctr) begin
            out_frame++;  // index wrapped.
         end
         prev_ctr = ctr_o;
         assert (out_frame < FRAMES) else begin
            $display("output %0d appeared after the last frame", carry_count);
            errors++;
         end
         if (out_frame < FRAMES) begin
            frame_outs[out_frame]++;
            check_output(out_frame, ctr_o, z_re_o, z_im_o);
            checked++;
         end
         carry_count++;
      end
   end

   initial begin
      logic [15:0] bits;
      srst_n  = 1'b0;
      carry_i = 1'b0;
      x_re_i  = '0;
      x_im_i  = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      srst_n = 1'b1;
      for (int f = 0; f < FRAMES; f++) begin
         for (int j = 0; j < N; j++) begin
            if (f < RANDOM_FRAMES) begin
               take_bits(14, bits);
               stim_re[f][j] = $signed(bits[13:0]);
               take_bits(14, bits);
               stim_im[f][j] = $signed(bits[13:0]);
            end else begin
               stim_re[f][j] = 0;
               stim_im[f][j] = 0;
            end
            if (f == GAP_FRAME) begin
               take_bits(1, bits);
               if (bits[0]) begin
                  carry_i = 1'b0;  // one idle cycle inside the frame.
                  @(negedge clk);
               end
            end
            carry_i = 1'b1;
            x_re_i  = fft_types_pkg::sample_t'(stim_re[f][j]);
            x_im_i  = fft_types_pkg::sample_t'(stim_im[f][j]);
            @(negedge clk);
         end
      end
      carry_i = 1'b0;
      wait (carry_count >= TOTAL_OUTS);
      repeat (2 * LAT) @(negedge clk);  // room for stray outputs.
      for (int f = 0; f < FRAMES; f++) begin
         assert (frame_outs[f] == ((f < RANDOM_FRAMES) ? N : HALF)) else begin
            $display("FAILED frame_count frame %0d: expected %0d, actual %0d",
                     f, (f < RANDOM_FRAMES) ? N : HALF, frame_outs[f]);
            errors++;
         end
      end
      sva_fails = i_fft_sdf_stage.i_fft_sdf_stage_sva.fail_count;
      $display("errors %0d, assertion failures %0d, carry_o seen %0d, outputs checked %0d",
               errors, sva_fails, carry_count, checked);
      if (errors == 0 && sva_fails == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- sim/fft_sdf_stage_sva.sv
`timescale 1ns/1ns

module fft_sdf_stage_sva #(
   parameter int N = 16
) (
   input logic                    clk,
   input logic                    srst_n,
   input logic                    carry_i,
   input logic                    carry_o,
   input logic [$clog2(N)-1:0]    ctr_o,
   input fft_ctrl_pkg::bf_phase_t bf_phase_i
);

   localparam int            IW       = $clog2(N);
   localparam int            LAT      = fft_ctrl_pkg::STAGE_LATENCY;
   localparam logic [IW-1:0] HALF_CNT = IW'(N / 2);

   logic [IW-1:0] seen;      // valid inputs since reset up to N/2.
   logic [IW-1:0] next_idx;  // index the next output has to carry.
   logic          emit_in;
   int            fail_count = 0;  // assertion failures so far.

   // inputs after the first half frame each produce one output.
   assign emit_in = carry_i && (seen == HALF_CNT);

   always_ff @(posedge clk) begin
      if (!srst_n) begin
         seen     <= '0;
         next_idx <= '0;
      end else begin
         if (carry_i && (seen != HALF_CNT)) begin
            seen <= seen + 1'b1;
         end
         if (carry_o) begin
            next_idx <= next_idx + 1'b1;  // wraps at N.
         end
      end
   end

   a_reset_quiet: assert property (@(posedge clk) !srst_n |=> !carry_o)
      else begin
         $error("carry_o is high in the cycle after reset");
         fail_count++;
      end

   a_reset_phase: assert property (@(posedge clk)
      !srst_n |=> (bf_phase_i == fft_ctrl_pkg::PH_FILL))
      else begin
         $error("butterfly phase is not fill in the cycle after reset");
         fail_count++;
      end

   a_carry_known: assert property (@(posedge clk) disable iff (!srst_n) !$isunknown(carry_o))
      else begin
         $error("carry_o is unknown after reset");
         fail_count++;
      end

   a_latency_fwd: assert property (@(posedge clk) disable iff (!srst_n)
      emit_in |-> ##LAT carry_o)
      else begin
         $error("an emitting input produced no carry_o after the stage latency");
         fail_count++;
      end

   a_latency_back: assert property (@(posedge clk) disable iff (!srst_n)
      carry_o |-> $past(emit_in, LAT))
      else begin
         $error("carry_o appeared without an emitting input one latency earlier");
         fail_count++;
      end

   a_index_order: assert property (@(posedge clk) disable iff (!srst_n)
      carry_o |-> (ctr_o == next_idx))
      else begin
         $error("output index does not follow the previous one");
         fail_count++;
      end

endmodule

bind fft_sdf_stage fft_sdf_stage_sva #(
   .N (N)
) i_fft_sdf_stage_sva (
   .clk        (clk),
   .srst_n     (srst_n),
   .carry_i    (carry_i),
   .carry_o    (carry_o),
   .ctr_o      (ctr_o),
   .bf_phase_i (i_fft_butterfly.phase)
);

//--- design/fft_sdf_stage.sv
`timescale 1ns/1ns

module fft_sdf_stage #(
   parameter int N = 16
) (
   input  logic                   clk,
   input  logic                   srst_n,
   input  logic                   carry_i,
   input  fft_types_pkg::sample_t x_re_i,
   input  fft_types_pkg::sample_t x_im_i,
   output logic                   carry_o,
   output logic [$clog2(N)-1:0]   ctr_o,
   output fft_types_pkg::sample_t z_re_o,
   output fft_types_pkg::sample_t z_im_o
);

   localparam int IW = $clog2(N);

   logic                    mem_wr;
   logic                    mem_rd;
   logic [IW-2:0]           mem_addr;  // half frame address.
   fft_types_pkg::sample_t  mem_wre;
   fft_types_pkg::sample_t  mem_wim;
   fft_types_pkg::sample_t  mem_rre;
   fft_types_pkg::sample_t  mem_rim;
   logic                    bf_carry;
   logic [IW-1:0]           bf_ctr;
   fft_types_pkg::sample_t  bf_re;
   fft_types_pkg::sample_t  bf_im;
   fft_types_pkg::twiddle_t w_re;
   fft_types_pkg::twiddle_t w_im;

   fft_butterfly #(
      .N (N)
   ) i_fft_butterfly (
      .clk        (clk),
      .srst_n     (srst_n),
      .carry_i    (carry_i),
      .x_re_i     (x_re_i),
      .x_im_i     (x_im_i),
      .mem_wr_o   (mem_wr),
      .mem_rd_o   (mem_rd),
      .mem_addr_o (mem_addr),
      .mem_wre_o  (mem_wre),
      .mem_wim_o  (mem_wim),
      .mem_rre_i  (mem_rre),
      .mem_rim_i  (mem_rim),
      .carry_o    (bf_carry),
      .ctr_o      (bf_ctr),
      .y_re_o     (bf_re),
      .y_im_o     (bf_im)
   );

   fft_delay_line #(
      .N (N)
   ) i_fft_delay_line (
      .clk    (clk),
      .wr_i   (mem_wr),
      .rd_i   (mem_rd),
      .addr_i (mem_addr),
      .wre_i  (mem_wre),
      .wim_i  (mem_wim),
      .rre_o  (mem_rre),
      .rim_o  (mem_rim)
   );

   // registered twiddle arrives one cycle after the butterfly output.
   fft_twiddle_rom #(
      .N (N)
   ) i_fft_twiddle_rom (
      .clk    (clk),
      .idx_i  (bf_ctr),
      .w_re_o (w_re),
      .w_im_o (w_im)
   );

   fft_wm #(
      .N (N)
   ) i_fft_wm (
      .clk       (clk),
      .srst_n    (srst_n),
      .carry_in  (bf_carry),
      .ctr_i     (bf_ctr),
      .x_re_i    (bf_re),
      .x_im_i    (bf_im),
      .w_re_i    (w_re),
      .w_im_i    (w_im),
      .carry_out (carry_o),
      .ctr_o     (ctr_o),
      .z_re_o    (z_re_o),
      .z_im_o    (z_im_o)
   );

endmodule

//--- design/fft_wm.sv
`timescale 1ns/1ns

module fft_wm #(
   parameter int N = 16
) (
   input  logic                    clk,
   input  logic                    srst_n,
   input  logic                    carry_in,
   input  logic [$clog2(N)-1:0]    ctr_i,
   input  fft_types_pkg::sample_t  x_re_i,
   input  fft_types_pkg::sample_t  x_im_i,
   input  fft_types_pkg::twiddle_t w_re_i,  // one cycle behind x.
   input  fft_types_pkg::twiddle_t w_im_i,
   output logic                    carry_out,
   output logic [$clog2(N)-1:0]    ctr_o,
   output fft_types_pkg::sample_t  z_re_o,
   output fft_types_pkg::sample_t  z_im_o
);

   localparam int IW   = $clog2(N);
   localparam int DW   = fft_types_pkg::DATA_WIDTH;
   localparam int PW   = fft_types_pkg::PROD_WIDTH;
   localparam int LAT  = fft_ctrl_pkg::WM_LATENCY;
   localparam int KW   = PW - 1;   // product without its msb.
   localparam int FRAC = KW - DW;  // bits dropped, TWIDDLE_WIDTH-1.

   fft_types_pkg::sample_t  xa_re;  // x one cycle late.
   fft_types_pkg::sample_t  xa_im;
   fft_types_pkg::sample_t  xb_re;  // x two cycles late.
   fft_types_pkg::sample_t  xb_im;
   fft_types_pkg::twiddle_t wa_re;
   fft_types_pkg::twiddle_t wa_im;
   fft_types_pkg::prod_t    kar_f;
   fft_types_pkg::prod_t    kar_r;
   fft_types_pkg::prod_t    kar_i;
   logic [LAT-1:0]          carry_sr;
   logic [IW-1:0]           ctr_sr [LAT];

   // |w| never exceeds 2^(TW-1), so the product msb only repeats the sign.
   // round half to even on bit FRAC, then keep the top DW bits.
   function automatic fft_types_pkg::sample_t round_conv(input fft_types_pkg::prod_t p);
      logic [KW-1:0] t;
      logic [KW-1:0] bias;
      t    = p[KW-1:0];
      bias = {{DW{1'b0}}, t[FRAC], {(FRAC - 1){~t[FRAC]}}};
      t    = t + bias;
      return t[KW-1:FRAC];
   endfunction

   // (a+jb)(c+jd) with f = c(a-b), re = b(c-d)+f, im = a(c+d)-f.
   always_ff @(posedge clk) begin
      xa_re <= x_re_i;
      xa_im <= x_im_i;
      xb_re <= xa_re;
      xb_im <= xa_im;
      wa_re <= w_re_i;
      wa_im <= w_im_i;

      kar_f <= fft_types_pkg::prod_t'(w_re_i)
               * (fft_types_pkg::prod_t'(xa_re) - fft_types_pkg::prod_t'(xa_im));
      kar_r <= fft_types_pkg::prod_t'(xb_im)
               * (fft_types_pkg::prod_t'(wa_re) - fft_types_pkg::prod_t'(wa_im)) + kar_f;
      kar_i <= fft_types_pkg::prod_t'(xb_re)
               * (fft_types_pkg::prod_t'(wa_re) + fft_types_pkg::prod_t'(wa_im)) - kar_f;

      z_re_o <= round_conv(kar_r);
      z_im_o <= round_conv(kar_i);
   end

   always_ff @(posedge clk) begin
      if (!srst_n) begin
         carry_sr <= '0;
      end else begin
         carry_sr <= {carry_sr[LAT-2:0], carry_in};
      end
   end

   // index rides along with the data.
   always_ff @(posedge clk) begin
      ctr_sr[0] <= ctr_i;
      for (int i = 1; i < LAT; i++) begin
         ctr_sr[i] <= ctr_sr[i-1];
      end
   end

   assign carry_out = carry_sr[LAT-1];
   assign ctr_o     = ctr_sr[LAT-1];

endmodule

//--- design/fft_twiddle_rom.sv
`timescale 1ns/1ns

module fft_twiddle_rom #(
   parameter int N = 16
) (
   input  logic                    clk,
   input  logic [$clog2(N)-1:0]    idx_i,
   output fft_types_pkg::twiddle_t w_re_o,
   output fft_types_pkg::twiddle_t w_im_o
);

   localparam int  TW    = fft_types_pkg::TWIDDLE_WIDTH;
   localparam real PI    = 3.14159265358979323846;
   localparam real W_MAX = (2.0 ** (TW - 1)) - 1.0;  // largest positive twiddle.

   fft_types_pkg::twiddle_t rom_re [N];
   fft_types_pkg::twiddle_t rom_im [N];

   // sums pass with unit gain, differences get exp(-j*2*pi*k/N).
   function automatic fft_types_pkg::twiddle_t twiddle_part(input int m, input bit imag);
      real ang;
      real v;
      if (m < N / 2) begin
         v = imag ? 0.0 : 1.0;
      end else begin
         ang = 2.0 * PI * real'(m - N / 2) / real'(N);
         v   = imag ? -$sin(ang) : $cos(ang);
      end
      return fft_types_pkg::twiddle_t'(int'(v * W_MAX));  // int'() rounds to nearest.
   endfunction

   for (genvar m = 0; m < N; m++) begin : g_rom
      localparam fft_types_pkg::twiddle_t W_RE = twiddle_part(m, 1'b0);
      localparam fft_types_pkg::twiddle_t W_IM = twiddle_part(m, 1'b1);

      assign rom_re[m] = W_RE;
      assign rom_im[m] = W_IM;
   end

   always_ff @(posedge clk) begin
      w_re_o <= rom_re[idx_i];
      w_im_o <= rom_im[idx_i];
   end

endmodule

//--- design/fft_butterfly.sv
`timescale 1ns/1ns

module fft_butterfly #(
   parameter int N = 16
) (
   input  logic                   clk,
   input  logic                   srst_n,
   input  logic                   carry_i,
   input  fft_types_pkg::sample_t x_re_i,
   input  fft_types_pkg::sample_t x_im_i,
   output logic                   mem_wr_o,
   output logic                   mem_rd_o,
   output logic [$clog2(N)-2:0]   mem_addr_o,
   output fft_types_pkg::sample_t mem_wre_o,
   output fft_types_pkg::sample_t mem_wim_o,
   input  fft_types_pkg::sample_t mem_rre_i,
   input  fft_types_pkg::sample_t mem_rim_i,
   output logic                   carry_o,
   output logic [$clog2(N)-1:0]   ctr_o,
   output fft_types_pkg::sample_t y_re_o,
   output fft_types_pkg::sample_t y_im_o
);

   localparam int IW = $clog2(N);
   localparam int DW = fft_types_pkg::DATA_WIDTH;

   logic [IW-1:0]           cnt;       // input index in frame.
   fft_ctrl_pkg::bf_phase_t in_phase;  // phase of the incoming sample.
   fft_ctrl_pkg::bf_phase_t phase;     // phase of the registered sample.
   logic                    emit;      // first half frame is behind us.
   logic                    s_valid;
   logic                    s_emit;
   logic [IW-1:0]           s_idx;
   fft_types_pkg::sample_t  s_re;
   fft_types_pkg::sample_t  s_im;
   fft_types_pkg::sample_t  sum_re;
   fft_types_pkg::sample_t  sum_im;
   fft_types_pkg::sample_t  diff_re;
   fft_types_pkg::sample_t  diff_im;

   // arithmetic shift right by one, truncating toward minus infinity.
   function automatic fft_types_pkg::sample_t halve(input logic signed [DW:0] v);
      return v[DW:1];
   endfunction

   if (N < 4 || (N & (N - 1)) != 0 || IW > fft_types_pkg::MAX_INDEX_WIDTH) begin : g_bad_n
      $error("fft_butterfly: N must be a power of two from 4 to 1024");
   end

   assign in_phase = fft_ctrl_pkg::bf_phase_t'(cnt[IW-1]);

   always_ff @(posedge clk) begin
      if (!srst_n) begin
         cnt     <= '0;
         phase   <= fft_ctrl_pkg::PH_FILL;
         emit    <= 1'b0;
         s_valid <= 1'b0;
         s_emit  <= 1'b0;
      end else begin
         s_valid <= carry_i;
         if (carry_i) begin
            cnt    <= cnt + 1'b1;  // wraps at N.
            phase  <= in_phase;
            s_emit <= emit || (in_phase == fft_ctrl_pkg::PH_PAIR);
            if (in_phase == fft_ctrl_pkg::PH_PAIR) begin
               emit <= 1'b1;
            end
         end
      end
   end

   // sample register, lines up with the delay line read data.
   always_ff @(posedge clk) begin
      if (carry_i) begin
         s_re  <= x_re_i;
         s_im  <= x_im_i;
         s_idx <= {~cnt[IW-1], cnt[IW-2:0]};  // j-N/2 in pair, j+N/2 in fill.
      end
   end

   assign mem_rd_o   = carry_i;
   assign mem_addr_o = cnt[IW-2:0];

   assign sum_re  = halve(mem_rre_i + s_re);
   assign sum_im  = halve(mem_rim_i + s_im);
   assign diff_re = halve(mem_rre_i - s_re);
   assign diff_im = halve(mem_rim_i - s_im);

   // fill stores the input, pair stores the difference.
   assign mem_wr_o  = s_valid;
   assign mem_wre_o = (phase == fft_ctrl_pkg::PH_PAIR) ? diff_re : s_re;
   assign mem_wim_o = (phase == fft_ctrl_pkg::PH_PAIR) ? diff_im : s_im;

   assign carry_o = s_valid & s_emit;
   assign ctr_o   = s_idx;
   assign y_re_o  = (phase == fft_ctrl_pkg::PH_PAIR) ? sum_re : mem_rre_i;  // else old diff.
   assign y_im_o  = (phase == fft_ctrl_pkg::PH_PAIR) ? sum_im : mem_rim_i;

endmodule

//--- design/fft_delay_line.sv
`timescale 1ns/1ns

module fft_delay_line #(
   parameter int N = 16
) (
   input  logic                   clk,
   input  logic                   wr_i,
   input  logic                   rd_i,
   input  logic [$clog2(N)-2:0]   addr_i,
   input  fft_types_pkg::sample_t wre_i,
   input  fft_types_pkg::sample_t wim_i,
   output fft_types_pkg::sample_t rre_o,
   output fft_types_pkg::sample_t rim_o
);

   localparam int DEPTH = N / 2;
   localparam int AW    = $clog2(DEPTH);

   fft_types_pkg::sample_t mem_re [DEPTH];
   fft_types_pkg::sample_t mem_im [DEPTH];

   // address of the last read, the write that follows goes back there.
   logic [AW-1:0] wr_addr;

   // read port, old contents come out one clock later.
   always_ff @(posedge clk) begin
      if (rd_i) begin
         rre_o   <= mem_re[addr_i];
         rim_o   <= mem_im[addr_i];
         wr_addr <= addr_i;
      end
   end

   // write back lands one cycle behind its read.
   always_ff @(posedge clk) begin
      if (wr_i) begin
         mem_re[wr_addr] <= wre_i;
         mem_im[wr_addr] <= wim_i;
      end
   end

endmodule

//--- design/fft_ctrl_pkg.sv
package fft_ctrl_pkg;

   // first half of a frame fills the delay line, second half pairs with it.
   typedef enum logic {
      PH_FILL = 1'b0,
      PH_PAIR = 1'b1
   } bf_phase_t;

   localparam int BF_LATENCY = 1;  // butterfly input register.
   localparam int WM_LATENCY = 4;  // multiplier pipeline.

   // carry_i to carry_o of the whole stage.
   localparam int STAGE_LATENCY = BF_LATENCY + WM_LATENCY;

endpackage

//--- design/fft_types_pkg.sv
package fft_types_pkg;

   // sample component width.
   localparam int DATA_WIDTH = 16;

   // twiddle component width, one sign bit and 17 fraction bits.
   localparam int TWIDDLE_WIDTH = 18;

   // full karatsuba product.
   localparam int PROD_WIDTH = DATA_WIDTH + TWIDDLE_WIDTH;

   // index width for the largest N of 1024.
   localparam int MAX_INDEX_WIDTH = 10;

   typedef logic signed [DATA_WIDTH-1:0]    sample_t;   // one complex component.
   typedef logic signed [TWIDDLE_WIDTH-1:0] twiddle_t;  // one twiddle component.
   typedef logic signed [PROD_WIDTH-1:0]    prod_t;     // multiplier internals.

endpackage
